/* soc_bus_params.svh */
//////////////////////////////////////////////////
// bus widths and memory map of the AHB-Lite fabric
// include wherever a width or a region is needed
//////////////////////////////////////////////////

`ifndef SOC_BUS_PARAMS_SVH
`define SOC_BUS_PARAMS_SVH

//////////////////////////////////////////////////
// bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

//////////////////////////////////////////////////
// regions, a hit is (haddr & MASK) == BASE
`define RAM_BASE   32'h2000_0000
`define RAM_MASK   32'hFFFF_F000   // 4 KB
`define RAM_WORDS  1024

`define SCR_BASE   32'h4000_1000
`define SCR_MASK   32'hFFFF_F800   // 2 KB
`define SCR_WORDS  512

`define TMR_BASE   32'h4000_0400
`define TMR_MASK   32'hFFFF_FFC0   // 64 byte register window

`endif

/* ahb_pkg.sv */
//////////////////////////////////////////////////
// AHB-Lite protocol types shared by the fabric,
// the slaves and the testbench
//////////////////////////////////////////////////

package ahb_pkg;

   // transfer kind
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_t;

   // transfer size, nothing wider than a word on this bus
   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010
   } hsize_t;

   typedef enum logic {
      HRESP_OKAY  = 1'b0,
      HRESP_ERROR = 1'b1
   } hresp_t;

   // true for a transfer that really moves data
   function automatic logic is_active(htrans_t t);
      return (t == HTRANS_NONSEQ) || (t == HTRANS_SEQ);
   endfunction

endpackage

/* soc_map_pkg.sv */
//////////////////////////////////////////////////
// memory map types, slave codes of the decoder
// and the register layout of the timer
//////////////////////////////////////////////////

package soc_map_pkg;

   // region code, also the data-phase mux select
   typedef enum logic [1:0] {
      SLV_RAM  = 2'd0,
      SLV_SCR  = 2'd1,
      SLV_TMR  = 2'd2,
      SLV_NONE = 2'd3   // default slave
   } slave_idx_t;

   // byte offsets inside the timer window
   typedef enum logic [5:0] {
      TMR_CTRL     = 6'h00,
      TMR_PRESCALE = 6'h04,
      TMR_COUNT    = 6'h08,
      TMR_COMPARE  = 6'h0C,
      TMR_STATUS   = 6'h10
   } tmr_reg_t;

   //////////////////////////////////////////////////
   // CTRL bits
   localparam int TMR_CTRL_EN     = 0;   // counter runs
   localparam int TMR_CTRL_IRQ_EN = 1;   // pending drives irq

   // STATUS bit 0 is pending, write 1 to clear
   localparam int TMR_STATUS_PEND = 0;

endpackage

/* ahb_slave_if.sv */
//////////////////////////////////////////////////
// one AHB-Lite slave port of the fabric
// the decoder takes fabric, each slave takes slave
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface ahb_slave_if #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
);

   // address phase and write data, from the fabric
   logic              hsel;
   logic [ADDR_W-1:0] haddr;
   logic              hwrite;
   ahb_pkg::hsize_t   hsize;
   ahb_pkg::htrans_t  htrans;
   logic [DATA_W-1:0] hwdata;
   logic              hready;     // bus-wide ready, ends the data phase

   // response, from the slave
   logic [DATA_W-1:0] hrdata;
   logic              hreadyout;
   ahb_pkg::hresp_t   hresp;

   modport fabric (
      output hsel, haddr, hwrite, hsize, htrans, hwdata, hready,
      input  hrdata, hreadyout, hresp
   );

   modport slave (
      input  hsel, haddr, hwrite, hsize, htrans, hwdata, hready,
      output hrdata, hreadyout, hresp
   );

endinterface

/* ahb_decoder.sv */
//////////////////////////////////////////////////
// address decoder and response mux of the fabric
// also holds the default slave for unmapped space
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_bus_params.svh"

module ahb_decoder (
   input  logic                   hclk_i,
   input  logic                   rst_i,
   input  logic [`AHB_ADDR_W-1:0] haddr_i,
   input  ahb_pkg::htrans_t       htrans_i,
   input  logic                   hwrite_i,
   input  ahb_pkg::hsize_t        hsize_i,
   input  logic [`AHB_DATA_W-1:0] hwdata_i,
   output logic [`AHB_DATA_W-1:0] hrdata_o,
   output logic                   hready_o,
   output ahb_pkg::hresp_t        hresp_o,
   ahb_slave_if.fabric            ram,
   ahb_slave_if.fabric            scr,
   ahb_slave_if.fabric            tmr
);

   typedef enum logic {
      DEF_IDLE,
      DEF_ERR_WAIT   // first error cycle, ready held low
   } def_state_t;

   soc_map_pkg::slave_idx_t addr_slv;       // region of the current address
   soc_map_pkg::slave_idx_t dphase_slv_q;   // region owning the data phase
   logic                    dphase_act_q;
   logic                    addr_act;
   def_state_t              def_state_q;

   //////////////////////////////////////////////////
   // address phase decode
   always_comb begin
      if ((haddr_i & `RAM_MASK) == `RAM_BASE) begin
         addr_slv = soc_map_pkg::SLV_RAM;
      end else if ((haddr_i & `SCR_MASK) == `SCR_BASE) begin
         addr_slv = soc_map_pkg::SLV_SCR;
      end else if ((haddr_i & `TMR_MASK) == `TMR_BASE) begin
         addr_slv = soc_map_pkg::SLV_TMR;
      end else begin
         addr_slv = soc_map_pkg::SLV_NONE;
      end
   end

   assign addr_act = ahb_pkg::is_active(htrans_i);

   assign ram.hsel   = (addr_slv == soc_map_pkg::SLV_RAM);
   assign ram.haddr  = haddr_i;
   assign ram.hwrite = hwrite_i;
   assign ram.hsize  = hsize_i;
   assign ram.htrans = htrans_i;
   assign ram.hwdata = hwdata_i;
   assign ram.hready = hready_o;

   assign scr.hsel   = (addr_slv == soc_map_pkg::SLV_SCR);
   assign scr.haddr  = haddr_i;
   assign scr.hwrite = hwrite_i;
   assign scr.hsize  = hsize_i;
   assign scr.htrans = htrans_i;
   assign scr.hwdata = hwdata_i;
   assign scr.hready = hready_o;

   assign tmr.hsel   = (addr_slv == soc_map_pkg::SLV_TMR);
   assign tmr.haddr  = haddr_i;
   assign tmr.hwrite = hwrite_i;
   assign tmr.hsize  = hsize_i;
   assign tmr.htrans = htrans_i;
   assign tmr.hwdata = hwdata_i;
   assign tmr.hready = hready_o;

   //////////////////////////////////////////////////
   // data phase owner and default slave
   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         dphase_slv_q <= soc_map_pkg::SLV_NONE;
         dphase_act_q <= 1'b0;
         def_state_q  <= DEF_IDLE;
      end else begin
         if (hready_o) begin   // address phase accepted
            dphase_slv_q <= addr_slv;
            dphase_act_q <= addr_act;
         end
         case (def_state_q)
            DEF_IDLE: begin
               if (hready_o && addr_act && addr_slv == soc_map_pkg::SLV_NONE) begin
                  def_state_q <= DEF_ERR_WAIT;
               end
            end
            default: def_state_q <= DEF_IDLE;   // second error cycle follows
         endcase
      end
   end

   // response mux
   always_comb begin
      case (dphase_slv_q)
         soc_map_pkg::SLV_RAM: begin
            hrdata_o = ram.hrdata;
            hready_o = ram.hreadyout;
            hresp_o  = ram.hresp;
         end
         soc_map_pkg::SLV_SCR: begin
            hrdata_o = scr.hrdata;
            hready_o = scr.hreadyout;
            hresp_o  = scr.hresp;
         end
         soc_map_pkg::SLV_TMR: begin
            hrdata_o = tmr.hrdata;
            hready_o = tmr.hreadyout;
            hresp_o  = tmr.hresp;
         end
         default: begin
            hrdata_o = '0;
            hready_o = (def_state_q != DEF_ERR_WAIT);
            hresp_o  = dphase_act_q ? ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_OKAY;
         end
      endcase
   end

endmodule

/* ahb_sram.sv */
//////////////////////////////////////////////////
// zero wait state word memory on an AHB-Lite port
// WORDS sets the depth, a power of two
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_sram #(
   parameter int WORDS = 1024
) (
   input  logic       hclk_i,
   input  logic       rst_i,
   ahb_slave_if.slave bus
);

   localparam int AW = $clog2(WORDS);

   logic [31:0]     mem [WORDS];

   logic            wr_q;       // data phase is a write
   logic [AW-1:0]   addr_q;     // word index
   logic [1:0]      lane_q;     // low address bits
   ahb_pkg::hsize_t size_q;
   logic [3:0]      be;
   logic            addr_sel;

   assign addr_sel = bus.hsel && bus.hready && ahb_pkg::is_active(bus.htrans);

   //////////////////////////////////////////////////
   // address phase
   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         wr_q <= 1'b0;
      end else if (bus.hready) begin
         wr_q <= addr_sel && bus.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (addr_sel) begin
         addr_q <= bus.haddr[AW+1:2];
         lane_q <= bus.haddr[1:0];
         size_q <= bus.hsize;
      end
   end

   // byte lanes of the registered transfer
   always_comb begin
      case (size_q)
         ahb_pkg::HSIZE_BYTE: be = 4'b0001 << lane_q;
         ahb_pkg::HSIZE_HALF: be = lane_q[1] ? 4'b1100 : 4'b0011;
         default:             be = 4'b1111;
      endcase
   end

   //////////////////////////////////////////////////
   // data phase, write lands at its last edge
   always_ff @(posedge hclk_i) begin
      if (wr_q && bus.hready) begin
         for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
               mem[addr_q][8*i +: 8] <= bus.hwdata[8*i +: 8];
            end
         end
      end
   end

   assign bus.hrdata    = mem[addr_q];
   assign bus.hreadyout = 1'b1;              // never stalls
   assign bus.hresp     = ahb_pkg::HRESP_OKAY;

endmodule

/* ahb_timer.sv */
//////////////////////////////////////////////////
// prescaled compare timer on an AHB-Lite port
// count wraps at COMPARE and raises pending
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ahb_timer (
   input  logic       hclk_i,
   input  logic       rst_i,
   ahb_slave_if.slave bus,
   output logic       irq_o
);

   logic [1:0]  ctrl_q;
   logic [31:0] prescale_q;
   logic [31:0] count_q;
   logic [31:0] compare_q;
   logic        pending_q;
   logic [31:0] presc_cnt_q;

   logic        wr_q;
   logic [5:0]  off_q;      // register offset of the data phase
   logic        addr_sel;
   logic        wr_en;
   logic        tick;       // counter advances this cycle
   logic        wrap;
   logic        clr_pend;

   assign addr_sel = bus.hsel && bus.hready && ahb_pkg::is_active(bus.htrans);
   assign wr_en    = wr_q && bus.hready;

   //////////////////////////////////////////////////
   // address phase
   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         wr_q <= 1'b0;
      end else if (bus.hready) begin
         wr_q <= addr_sel && bus.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (addr_sel) begin
         off_q <= bus.haddr[5:0];
      end
   end

   //////////////////////////////////////////////////
   // prescaler, counter and registers
   assign tick     = ctrl_q[soc_map_pkg::TMR_CTRL_EN] && (presc_cnt_q == prescale_q);
   assign wrap     = tick && (count_q == compare_q);
   assign clr_pend = wr_en && (off_q == soc_map_pkg::TMR_STATUS)
                     && bus.hwdata[soc_map_pkg::TMR_STATUS_PEND];

   always_ff @(posedge hclk_i) begin
      if (rst_i) begin
         ctrl_q      <= '0;
         prescale_q  <= '0;
         count_q     <= '0;
         compare_q   <= '0;
         pending_q   <= 1'b0;
         presc_cnt_q <= '0;
      end else begin
         if (!ctrl_q[soc_map_pkg::TMR_CTRL_EN] || tick) begin
            presc_cnt_q <= '0;
         end else begin
            presc_cnt_q <= presc_cnt_q + 32'd1;
         end

         if (wrap) begin
            count_q <= '0;
         end else if (tick) begin
            count_q <= count_q + 32'd1;
         end

         if (wr_en) begin   // bus write overrides the counter
            case (off_q)
               soc_map_pkg::TMR_CTRL:     ctrl_q <= bus.hwdata[1:0];
               soc_map_pkg::TMR_COUNT:    count_q <= bus.hwdata;
               soc_map_pkg::TMR_COMPARE:  compare_q <= bus.hwdata;
               soc_map_pkg::TMR_PRESCALE: begin
                  prescale_q  <= bus.hwdata;
                  presc_cnt_q <= '0;   // restart the divider
               end
               default: ;
            endcase
         end

         if (wrap) begin
            pending_q <= 1'b1;   // set beats clear
         end else if (clr_pend) begin
            pending_q <= 1'b0;
         end
      end
   end

   // read mux, unused offsets read zero
   always_comb begin
      case (off_q)
         soc_map_pkg::TMR_CTRL:     bus.hrdata = {30'd0, ctrl_q};
         soc_map_pkg::TMR_PRESCALE: bus.hrdata = prescale_q;
         soc_map_pkg::TMR_COUNT:    bus.hrdata = count_q;
         soc_map_pkg::TMR_COMPARE:  bus.hrdata = compare_q;
         soc_map_pkg::TMR_STATUS:   bus.hrdata = {31'd0, pending_q};
         default:                   bus.hrdata = '0;
      endcase
   end

   assign bus.hreadyout = 1'b1;
   assign bus.hresp     = ahb_pkg::HRESP_OKAY;

   assign irq_o = pending_q && ctrl_q[soc_map_pkg::TMR_CTRL_IRQ_EN];

endmodule

/* soc_top.sv */
//////////////////////////////////////////////////
// bus fabric top, one AHB-Lite master port outside
// main RAM, scratch RAM and timer behind the decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_bus_params.svh"

module soc_top (
   input  logic                   hclk_i,
   input  logic                   rst_i,
   input  logic [`AHB_ADDR_W-1:0] haddr_i,
   input  ahb_pkg::htrans_t       htrans_i,
   input  logic                   hwrite_i,
   input  ahb_pkg::hsize_t        hsize_i,
   input  logic [`AHB_DATA_W-1:0] hwdata_i,
   output logic [`AHB_DATA_W-1:0] hrdata_o,
   output logic                   hready_o,
   output ahb_pkg::hresp_t        hresp_o,
   output logic                   irq_o
);

   //////////////////////////////////////////////////
   // one slave port per region
   ahb_slave_if #(.ADDR_W(`AHB_ADDR_W), .DATA_W(`AHB_DATA_W)) ram_if ();
   ahb_slave_if #(.ADDR_W(`AHB_ADDR_W), .DATA_W(`AHB_DATA_W)) scr_if ();
   ahb_slave_if #(.ADDR_W(`AHB_ADDR_W), .DATA_W(`AHB_DATA_W)) tmr_if ();

   ahb_decoder u_dec (
      .hclk_i   ( hclk_i   ),
      .rst_i    ( rst_i    ),
      .haddr_i  ( haddr_i  ),
      .htrans_i ( htrans_i ),
      .hwrite_i ( hwrite_i ),
      .hsize_i  ( hsize_i  ),
      .hwdata_i ( hwdata_i ),
      .hrdata_o ( hrdata_o ),
      .hready_o ( hready_o ),
      .hresp_o  ( hresp_o  ),
      .ram      ( ram_if   ),
      .scr      ( scr_if   ),
      .tmr      ( tmr_if   ) );

   ahb_sram #(
      .WORDS  ( `RAM_WORDS ) )   // 4 KB main RAM
   u_ram (
      .hclk_i ( hclk_i     ),
      .rst_i  ( rst_i      ),
      .bus    ( ram_if     ) );

   ahb_sram #(
      .WORDS  ( `SCR_WORDS ) )   // 2 KB scratch
   u_scr (
      .hclk_i ( hclk_i     ),
      .rst_i  ( rst_i      ),
      .bus    ( scr_if     ) );

   ahb_timer u_tmr (
      .hclk_i ( hclk_i ),
      .rst_i  ( rst_i  ),
      .bus    ( tmr_if ),
      .irq_o  ( irq_o  ) );

endmodule

/* soc_top_props.sv */
//////////////////////////////////////////////////
// AHB-Lite response rules of the fabric top level
// bound into soc_top, failures counted in prop_errs
//////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_top_props (
   input logic            hclk_i,
   input logic            rst_i,
   input logic            hready_o,
   input ahb_pkg::hresp_t hresp_o,
   input logic            irq_o
);

   int prop_errs = 0;   // read by the testbench at the end

   // only the default slave ever stalls
   a_stall_is_error: assert property (@(posedge hclk_i) disable iff (rst_i)
      !hready_o |-> hresp_o == ahb_pkg::HRESP_ERROR)
   else begin
      prop_errs++;
      $error("hready_o low without an ERROR response");
   end

   // first error cycle is followed by the closing one
   a_err_second: assert property (@(posedge hclk_i) disable iff (rst_i)
      (!hready_o && hresp_o == ahb_pkg::HRESP_ERROR)
      |=> (hready_o && hresp_o == ahb_pkg::HRESP_ERROR))
   else begin
      prop_errs++;
      $error("error response did not end in its second cycle");
   end

   // a closing error cycle needs the stalled one before it
   a_err_first: assert property (@(posedge hclk_i) disable iff (rst_i)
      (hready_o && hresp_o == ahb_pkg::HRESP_ERROR)
      |-> $past(!hready_o && hresp_o == ahb_pkg::HRESP_ERROR))
   else begin
      prop_errs++;
      $error("error response with hready_o high was not preceded by a stalled cycle");
   end

   a_reset_state: assert property (@(posedge hclk_i)
      rst_i |=> (hready_o && hresp_o == ahb_pkg::HRESP_OKAY && !irq_o))
   else begin
      prop_errs++;
      $error("bus not idle or irq_o set after reset");
   end

endmodule

bind soc_top soc_top_props u_props (
   .hclk_i   ( hclk_i   ),
   .rst_i    ( rst_i    ),
   .hready_o ( hready_o ),
   .hresp_o  ( hresp_o  ),
   .irq_o    ( irq_o    ) );

/* tb_soc_top.sv */
//////////////////////////////////////////////////
// testbench of the AHB-Lite fabric top level
// drives single transfers, keeps shadow memories,
// checks read data and the timer interrupt
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_bus_params.svh"

module tb_soc_top;

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 16;
   localparam int N_RAND     = 16;
   localparam int N_XFERS    = 4*N_RAND + 74;   // random, lanes, map, unmapped and timer
   localparam int IRQ_LIMIT  = 2*6 + 2;         // (PRESCALE+1) * (COMPARE+1) + 2
   localparam int TMR_WAIT   = 3*IRQ_LIMIT;
   localparam int WDOG_CYC   = RST_CYCLES + 4*N_XFERS + TMR_WAIT + 200;

   logic                   hclk_i = 1'b0;
   logic                   rst_i;
   logic [`AHB_ADDR_W-1:0] haddr_i;
   ahb_pkg::htrans_t       htrans_i;
   logic                   hwrite_i;
   ahb_pkg::hsize_t        hsize_i;
   logic [`AHB_DATA_W-1:0] hwdata_i;
   logic [`AHB_DATA_W-1:0] hrdata_o;
   logic                   hready_o;
   ahb_pkg::hresp_t        hresp_o;
   logic                   irq_o;

   logic [31:0] ram_sh [`RAM_WORDS];   // shadow of main RAM
   logic [31:0] scr_sh [`SCR_WORDS];   // shadow of scratch RAM
   int          errors = 0;
   integer      seed   = 37718;

   always #(CLK_PERIOD/2) hclk_i = ~hclk_i;

   soc_top u_dut (
      .hclk_i   ( hclk_i   ),
      .rst_i    ( rst_i    ),
      .haddr_i  ( haddr_i  ),
      .htrans_i ( htrans_i ),
      .hwrite_i ( hwrite_i ),
      .hsize_i  ( hsize_i  ),
      .hwdata_i ( hwdata_i ),
      .hrdata_o ( hrdata_o ),
      .hready_o ( hready_o ),
      .hresp_o  ( hresp_o  ),
      .irq_o    ( irq_o    ) );

   //////////////////////////////////////////////////
   // value checks and expected data

   task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("error at %0t ns: %s got 0x%08h expected 0x%08h", $time, sig, got, exp);
      end
   endtask

   task automatic check_okay(input int waits, input logic err);
      assert (waits == 0) else begin
         errors++;
         $display("error at %0t ns: hready_o wait cycles got %0d expected 0", $time, waits);
      end
      assert (!err) else begin
         errors++;
         $display("error at %0t ns: hresp_o got ERROR expected OKAY", $time);
      end
   endtask

   // word after a byte or halfword write at a size aligned low address
   function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wdata,
                                               input ahb_pkg::hsize_t sz, input logic [1:0] low);
      logic [31:0] res;
      int          nbytes;
      res    = old;
      nbytes = 1 << int'(sz);
      for (int b = int'(low); b < int'(low) + nbytes; b++) begin
         res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] tmr_addr(input soc_map_pkg::tmr_reg_t r);
      return `TMR_BASE | 32'(r);
   endfunction

   //////////////////////////////////////////////////
   // single bus transfers

   // returns on the edge that closes the data phase
   task automatic bus_xfer(input logic [31:0] addr, input logic wr, input ahb_pkg::hsize_t sz,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output int waits, output logic err);
      haddr_i  <= addr;
      htrans_i <= ahb_pkg::HTRANS_NONSEQ;
      hwrite_i <= wr;
      hsize_i  <= sz;
      @(posedge hclk_i);
      while (!hready_o) begin   // address phase held until accepted
         @(posedge hclk_i);
      end
      htrans_i <= ahb_pkg::HTRANS_IDLE;
      hwdata_i <= wdata;
      waits = 0;
      err   = 1'b0;
      @(posedge hclk_i);
      while (!hready_o) begin
         err = err | (hresp_o == ahb_pkg::HRESP_ERROR);
         waits++;
         @(posedge hclk_i);
      end
      err   = err | (hresp_o == ahb_pkg::HRESP_ERROR);
      rdata = hrdata_o;
   endtask

   task automatic write_mem(input logic [31:0] addr, input ahb_pkg::hsize_t sz,
                            input logic [31:0] data);
      logic [31:0] rd;
      int          waits;
      logic        err;
      bus_xfer(addr, 1'b1, sz, data, rd, waits, err);
      check_okay(waits, err);
   endtask

   task automatic read_value(input logic [31:0] addr, output logic [31:0] rd);
      int   waits;
      logic err;
      bus_xfer(addr, 1'b0, ahb_pkg::HSIZE_WORD, '0, rd, waits, err);
      check_okay(waits, err);
   endtask

   task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
      logic [31:0] rd;
      read_value(addr, rd);
      check_eq("hrdata_o", rd, exp);
   endtask

   // sub-word write into a known word and a word read of the merge
   task automatic partial_check(input logic [31:0] base, input int idx,
                                input ahb_pkg::hsize_t sz, inout logic [31:0] word);
      logic [1:0]  low;
      logic [31:0] data;
      low  = 2'($random(seed));
      if (sz == ahb_pkg::HSIZE_HALF) begin
         low[0] = 1'b0;
      end
      data = $random(seed);
      write_mem(base + 4*idx + low, sz, data);
      word = merge_lanes(word, data, sz, low);
      read_check(base + 4*idx, word);
   endtask

   //////////////////////////////////////////////////
   // stimulus

   initial begin
      logic [31:0] rd;
      logic [31:0] data;
      int          idx;
      int          waits;
      logic        err;
      int          cyc;
      int          ram_idx [$];
      int          scr_idx [$];

      rst_i    = 1'b1;
      haddr_i  = '0;
      htrans_i = ahb_pkg::HTRANS_IDLE;
      hwrite_i = 1'b0;
      hsize_i  = ahb_pkg::HSIZE_WORD;
      hwdata_i = '0;
      repeat (RST_CYCLES) @(posedge hclk_i);
      rst_i <= 1'b0;
      @(posedge hclk_i);

      // random words in both memories
      for (int i = 0; i < N_RAND; i++) begin
         idx  = $unsigned($random(seed)) % `RAM_WORDS;
         data = $random(seed);
         ram_sh[idx] = data;
         ram_idx.push_back(idx);
         write_mem(`RAM_BASE + 4*idx, ahb_pkg::HSIZE_WORD, data);
         idx  = $unsigned($random(seed)) % `SCR_WORDS;
         data = $random(seed);
         scr_sh[idx] = data;
         scr_idx.push_back(idx);
         write_mem(`SCR_BASE + 4*idx, ahb_pkg::HSIZE_WORD, data);
      end
      foreach (ram_idx[i]) begin
         read_check(`RAM_BASE + 4*ram_idx[i], ram_sh[ram_idx[i]]);
         read_check(`SCR_BASE + 4*scr_idx[i], scr_sh[scr_idx[i]]);
      end

      // byte and halfword lanes
      for (int k = 0; k < 4; k++) begin
         partial_check(`RAM_BASE, ram_idx[k], ahb_pkg::HSIZE_BYTE, ram_sh[ram_idx[k]]);
         partial_check(`RAM_BASE, ram_idx[k], ahb_pkg::HSIZE_HALF, ram_sh[ram_idx[k]]);
         partial_check(`SCR_BASE, scr_idx[k], ahb_pkg::HSIZE_BYTE, scr_sh[scr_idx[k]]);
         partial_check(`SCR_BASE, scr_idx[k], ahb_pkg::HSIZE_HALF, scr_sh[scr_idx[k]]);
      end

      // same offset in both regions
      data = $random(seed);
      ram_sh[32'h3F0 >> 2] = data;
      scr_sh[32'h3F0 >> 2] = ~data;
      write_mem(`RAM_BASE + 32'h3F0, ahb_pkg::HSIZE_WORD, data);
      write_mem(`SCR_BASE + 32'h3F0, ahb_pkg::HSIZE_WORD, ~data);
      read_check(`RAM_BASE + 32'h3F0, data);
      read_check(`SCR_BASE + 32'h3F0, ~data);

      // unmapped space gets the two cycle error
      bus_xfer(32'h6000_0000, 1'b0, ahb_pkg::HSIZE_WORD, '0, rd, waits, err);
      assert (err && waits == 1) else begin
         errors++;
         $display("unmapped read at 0x60000000 did not get a two cycle error response");
      end
      bus_xfer(32'h6000_0010, 1'b1, ahb_pkg::HSIZE_WORD, data, rd, waits, err);
      assert (err && waits == 1) else begin
         errors++;
         $display("unmapped write at 0x60000010 did not get a two cycle error response");
      end
      read_check(`RAM_BASE + 4*ram_idx[0], ram_sh[ram_idx[0]]);

      //////////////////////////////////////////////////
      // timer with interrupt enabled
      write_mem(tmr_addr(soc_map_pkg::TMR_PRESCALE), ahb_pkg::HSIZE_WORD, 32'd1);
      write_mem(tmr_addr(soc_map_pkg::TMR_COMPARE), ahb_pkg::HSIZE_WORD, 32'd5);
      read_check(tmr_addr(soc_map_pkg::TMR_PRESCALE), 32'd1);
      read_check(tmr_addr(soc_map_pkg::TMR_COMPARE), 32'd5);
      write_mem(tmr_addr(soc_map_pkg::TMR_CTRL), ahb_pkg::HSIZE_WORD, 32'd3);
      cyc = 0;
      while (!irq_o && cyc <= IRQ_LIMIT) begin
         @(posedge hclk_i);
         cyc++;
      end
      assert (cyc <= IRQ_LIMIT) else begin
         errors++;
         $display("irq_o did not rise within %0d cycles of the CTRL write", IRQ_LIMIT);
      end
      for (int i = 0; i < 10; i++) begin
         read_value(tmr_addr(soc_map_pkg::TMR_COUNT), rd);
         assert (rd <= 32'd5) else begin
            errors++;
            $display("error at %0t ns: COUNT got %0d expected at most 5", $time, rd);
         end
      end

      // stop the count and clear pending
      write_mem(tmr_addr(soc_map_pkg::TMR_CTRL), ahb_pkg::HSIZE_WORD, 32'd2);
      read_check(tmr_addr(soc_map_pkg::TMR_STATUS), 32'd1);
      check_eq("irq_o", 32'(irq_o), 32'd1);
      write_mem(tmr_addr(soc_map_pkg::TMR_STATUS), ahb_pkg::HSIZE_WORD, 32'd1);
      @(posedge hclk_i);
      check_eq("irq_o", 32'(irq_o), 32'd0);

      // pending without irq-enable
      write_mem(tmr_addr(soc_map_pkg::TMR_CTRL), ahb_pkg::HSIZE_WORD, 32'd1);
      rd = '0;
      for (int i = 0; i < 16 && !rd[0]; i++) begin
         read_value(tmr_addr(soc_map_pkg::TMR_STATUS), rd);
         check_eq("irq_o", 32'(irq_o), 32'd0);
      end
      check_eq("STATUS", rd, 32'd1);

      @(posedge hclk_i);
      $display("run done: %0d data errors, %0d assertion errors",
               errors, u_dut.u_props.prop_errs);
      if (errors == 0 && u_dut.u_props.prop_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WDOG_CYC * CLK_PERIOD);
      $display("timeout: run did not finish within %0d cycles, %0d data errors so far",
               WDOG_CYC, errors);
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* soc_top.f */
+incdir+.
ahb_pkg.sv
soc_map_pkg.sv
ahb_slave_if.sv
ahb_decoder.sv
ahb_sram.sv
ahb_timer.sv
soc_top.sv
soc_top_props.sv
tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_top

export_include_dirs:
  - .

sources:
  - files:
      - ahb_pkg.sv
      - soc_map_pkg.sv
      - ahb_slave_if.sv
      - ahb_decoder.sv
      - ahb_sram.sv
      - ahb_timer.sv
      - soc_top.sv
  - target: test
    files:
      - soc_top_props.sv
      - tb_soc_top.sv
